/* verilog/afifo_pkg.sv */
package afifo_pkg;

  // FIFO geometry. DEPTH must be a power of two.
  localparam int DATA_W       = 8;
  localparam int DEPTH        = 16;
  localparam int ADDR_W       = $clog2(DEPTH);

  // Almost flag thresholds, in words.
  localparam int AFULL_LEVEL  = 12; // afull when used >= this.
  localparam int AEMPTY_LEVEL = 2;  // aempty when used <= this.

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Pointer with one extra wrap bit, binary or Gray.
  typedef logic [ADDR_W:0] ptr_t;

  // Write request from the write controller to the array.
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } ram_wr_t;

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  // Binary to Gray, shared by both controllers.
  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

/* verilog/gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync import afifo_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  ptr_t gray_in,
  output ptr_t bin_out
);

  ptr_t sync_q1;
  ptr_t sync_q2;

  // Two-flop capture of the foreign Gray pointer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // Gray to binary, running XOR from the MSB down.
  always_comb begin
    logic acc;
    acc = 1'b0;
    for (int i = ADDR_W; i >= 0; i--) begin
      acc        = acc ^ sync_q2[i];
      bin_out[i] = acc;
    end
  end

  // The foreign pointer only moves forward, and never by more than a full FIFO
  // between two local samples.
  a_fwd_only: assert property (
    @(posedge clk) disable iff (!rst_n)
    ptr_t'(bin_out - $past(bin_out)) <= ptr_t'(DEPTH)
  ) else $error("gray_ptr_sync: synchronized pointer moved backwards");

endmodule

/* verilog/afifo_wr_ctrl.sv */
`timescale 1ns/1ps

module afifo_wr_ctrl import afifo_pkg::*; (
  input  logic       wr_clk,
  input  logic       rst_n,
  input  logic       wr_en,
  input  data_t      wr_data,
  input  ptr_t       rd_ptr_ws,
  output ram_wr_t    ram_wr,
  output ptr_t       wr_gray,
  output wr_status_t wr_status
);

  ptr_t wr_ptr;
  ptr_t wr_ptr_nxt;
  ptr_t used_nxt;
  logic wr_fire;
  logic full_nxt;
  logic afull_nxt;

  assign wr_fire    = wr_en && !wr_status.full; // Writes against full are dropped.
  assign wr_ptr_nxt = wr_ptr + ptr_t'(wr_fire);

  // Used count as the write side sees it. Pessimistic by the sync delay.
  assign used_nxt   = wr_ptr_nxt - rd_ptr_ws;

  // Same slot on the other lap.
  assign full_nxt   = (wr_ptr_nxt == {~rd_ptr_ws[ADDR_W], rd_ptr_ws[ADDR_W-1:0]});
  assign afull_nxt  = (used_nxt >= ptr_t'(AFULL_LEVEL));

  always_comb begin
    ram_wr.en   = wr_fire;
    ram_wr.addr = wr_ptr[ADDR_W-1:0];
    ram_wr.data = wr_data;
  end

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      wr_gray   <= '0;
      wr_status <= '0;
    end else begin
      wr_ptr          <= wr_ptr_nxt;
      wr_gray         <= bin2gray(wr_ptr_nxt); // Registered for the crossing.
      wr_status.full  <= full_nxt;
      wr_status.afull <= afull_nxt;
    end
  end

  // The write pointer never runs more than a full FIFO past the read side.
  a_no_overflow: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    ptr_t'(wr_ptr - rd_ptr_ws) <= ptr_t'(DEPTH)
  ) else $error("afifo_wr_ctrl: write pointer ran more than a full FIFO ahead");

  // The read domain relies on single-bit Gray steps.
  a_gray_one_bit: assert property (
    @(posedge wr_clk) disable iff (!rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else $error("afifo_wr_ctrl: wr_gray changed in more than one bit");

endmodule

/* verilog/afifo_rd_ctrl.sv */
`timescale 1ns/1ps

module afifo_rd_ctrl import afifo_pkg::*; (
  input  logic       rd_clk,
  input  logic       rst_n,
  input  logic       rd_en,
  input  ptr_t       wr_ptr_rs,
  output logic       rd_fire,
  output addr_t      rd_addr,
  output ptr_t       rd_gray,
  output rd_status_t rd_status
);

  ptr_t rd_ptr;
  ptr_t rd_ptr_nxt;
  ptr_t avail_nxt;
  logic empty_nxt;
  logic aempty_nxt;

  assign rd_fire    = rd_en && !rd_status.empty; // Reads against empty are dropped.
  assign rd_ptr_nxt = rd_ptr + ptr_t'(rd_fire);
  assign rd_addr    = rd_ptr[ADDR_W-1:0];

  // Words visible to the read side after this cycle.
  assign avail_nxt  = wr_ptr_rs - rd_ptr_nxt;

  assign empty_nxt  = (rd_ptr_nxt == wr_ptr_rs);
  assign aempty_nxt = (avail_nxt <= ptr_t'(AEMPTY_LEVEL));

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr    <= '0;
      rd_gray   <= '0;
      rd_status <= '{empty: 1'b1, aempty: 1'b1}; // Nothing stored yet.
    end else begin
      rd_ptr           <= rd_ptr_nxt;
      rd_gray          <= bin2gray(rd_ptr_nxt);
      rd_status.empty  <= empty_nxt;
      rd_status.aempty <= aempty_nxt;
    end
  end

  // The synchronized write pointer is never more than a full FIFO ahead.
  a_avail_bounded: assert property (
    @(posedge rd_clk) disable iff (!rst_n)
    ptr_t'(wr_ptr_rs - rd_ptr) <= ptr_t'(DEPTH)
  ) else $error("afifo_rd_ctrl: write pointer ran past the read pointer");

endmodule

/* verilog/afifo_ram.sv */
`timescale 1ns/1ps

module afifo_ram import afifo_pkg::*; (
  input  logic    wr_clk,
  input  logic    rd_clk,
  input  logic    rst_n,
  input  ram_wr_t ram_wr,
  input  logic    rd_fire,
  input  addr_t   rd_addr,
  output data_t   rd_data
);

  data_t mem [DEPTH];

  // Write port, wr_clk domain.
  always_ff @(posedge wr_clk) begin
    if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Registered read port. Holds the last word between reads.
  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_fire) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* verilog/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo import afifo_pkg::*; (
  input  logic  wr_clk,
  input  logic  wr_rst_n,
  input  logic  wr_en,
  input  data_t wr_data,
  input  logic  rd_clk,
  input  logic  rd_en,
  output data_t rd_data,
  output logic  full,
  output logic  afull,
  output logic  empty,
  output logic  aempty
);

  logic [1:0] wr_rst_sync;
  logic [1:0] rd_rst_sync;
  logic       wr_side_rst_n;
  logic       rd_side_rst_n;

  ram_wr_t    ram_wr;
  ptr_t       wr_gray;
  ptr_t       rd_gray;
  ptr_t       wr_ptr_rs;
  ptr_t       rd_ptr_ws;
  logic       rd_fire;
  addr_t      rd_addr;
  wr_status_t wr_status;
  rd_status_t rd_status;

  // Reset asserts at once, releases on the local clock.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_rst_sync <= '0;
    end else begin
      wr_rst_sync <= {wr_rst_sync[0], 1'b1};
    end
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_rst_sync <= '0;
    end else begin
      rd_rst_sync <= {rd_rst_sync[0], 1'b1};
    end
  end

  assign wr_side_rst_n = wr_rst_sync[1];
  assign rd_side_rst_n = rd_rst_sync[1];

  afifo_wr_ctrl u_wr_ctrl (
    .wr_clk    (wr_clk),
    .rst_n     (wr_side_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_ptr_ws (rd_ptr_ws),
    .ram_wr    (ram_wr),
    .wr_gray   (wr_gray),
    .wr_status (wr_status)
  );

  // Write pointer into the read domain.
  gray_ptr_sync u_wr2rd_sync (
    .clk     (rd_clk),
    .rst_n   (rd_side_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rs)
  );

  afifo_rd_ctrl u_rd_ctrl (
    .rd_clk    (rd_clk),
    .rst_n     (rd_side_rst_n),
    .rd_en     (rd_en),
    .wr_ptr_rs (wr_ptr_rs),
    .rd_fire   (rd_fire),
    .rd_addr   (rd_addr),
    .rd_gray   (rd_gray),
    .rd_status (rd_status)
  );

  // Read pointer into the write domain.
  gray_ptr_sync u_rd2wr_sync (
    .clk     (wr_clk),
    .rst_n   (wr_side_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_ws)
  );

  afifo_ram u_ram (
    .wr_clk  (wr_clk),
    .rd_clk  (rd_clk),
    .rst_n   (rd_side_rst_n),
    .ram_wr  (ram_wr),
    .rd_fire (rd_fire),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  assign full   = wr_status.full;
  assign afull  = wr_status.afull;
  assign empty  = rd_status.empty;
  assign aempty = rd_status.aempty;

endmodule

/* tb/afifo_tb_checks.svh */
`ifndef AFIFO_TB_CHECKS_SVH
`define AFIFO_TB_CHECKS_SVH

// Flags once a fill level has settled in both clock domains.
function automatic void expected_flags(
  input  int         count,
  output wr_status_t ws,
  output rd_status_t rs
);
  ws.full   = (count == DEPTH);
  ws.afull  = (count >= AFULL_LEVEL);
  rs.empty  = (count == 0);
  rs.aempty = (count <= AEMPTY_LEVEL); // Low threshold is inclusive.
endfunction

task automatic check_data(
  input string name,
  input data_t exp,
  input data_t act
);
  if (act !== exp) begin
    $display("Mismatch in %s: expected data %02h, actual %02h", name, exp, act);
    fail_run();
  end
endtask

task automatic check_wr_status(
  input string      name,
  input wr_status_t exp,
  input wr_status_t act
);
  if (act !== exp) begin
    $display("Mismatch in %s: expected full=%b afull=%b, actual full=%b afull=%b",
             name, exp.full, exp.afull, act.full, act.afull);
    fail_run();
  end
endtask

task automatic check_rd_status(
  input string      name,
  input rd_status_t exp,
  input rd_status_t act
);
  if (act !== exp) begin
    $display("Mismatch in %s: expected empty=%b aempty=%b, actual empty=%b aempty=%b",
             name, exp.empty, exp.aempty, act.empty, act.aempty);
    fail_run();
  end
endtask

`endif

/* tb/tb_async_fifo.sv */
`timescale 1ns/1ps

module tb_async_fifo import afifo_pkg::*; ();

  localparam int RAND_CYCLES = 400; // Read clock cycles of mixed traffic.
  localparam int TOTAL_OPS   = 4 * (DEPTH + 8) + (DEPTH + 1) * 8 + RAND_CYCLES;

  logic  wr_clk;
  logic  rd_clk;
  logic  wr_rst_n;
  logic  wr_en;
  logic  rd_en;
  data_t wr_data;
  data_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  data_t  model[$];               // Words accepted and not yet read.
  string  test_name = "reset";
  logic   check_pending = 1'b0;
  data_t  exp_word;
  integer seed = 32'hff2;
  integer rd_seed;
  integer r_wr;
  integer r_rd;

  task automatic fail_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error.");
  endtask

  `include "afifo_tb_checks.svh"

  async_fifo i_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk; // Posedges at odd times never meet rd_clk.
  end

  // Write side of the model.
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model.push_back(wr_data);
      if (model.size() > DEPTH) begin
        $display("%s: more than %0d words were accepted", test_name, DEPTH);
        fail_run();
      end
    end
  end

  // Read side. Data is due one rd_clk after the accepting edge.
  always @(posedge rd_clk) begin
    if (check_pending) begin
      check_data(test_name, exp_word, rd_data);
      check_pending = 1'b0;
    end
    if (wr_rst_n && rd_en && !empty) begin
      if (model.size() == 0) begin
        $display("%s: a read was accepted with nothing stored", test_name);
        fail_run();
      end else begin
        exp_word      = model.pop_front();
        check_pending = 1'b1;
      end
    end
  end

  initial begin
    #(TOTAL_OPS * 6 * 8 + 200);
    $display("Watchdog expired, the test sequence did not complete in time");
    fail_run();
  end

  task automatic write_burst(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge wr_clk);
      wr_en   = 1'b1;
      wr_data = data_t'($random(seed));
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic compare_flags(input string name, input int count);
    wr_status_t exp_ws;
    rd_status_t exp_rs;
    expected_flags(count, exp_ws, exp_rs);
    check_wr_status(name, exp_ws, wr_status_t'({full, afull}));
    check_rd_status(name, exp_rs, rd_status_t'({empty, aempty}));
  endtask

  task automatic settle_check(input string name, input int count);
    repeat (5) @(negedge wr_clk);
    @(negedge rd_clk);
    if (model.size() != count) begin
      $display("%s: %0d words accepted, %0d expected", name, model.size(), count);
      fail_run();
    end
    compare_flags(name, count);
  endtask

  // Reads until the model and the DUT are both empty.
  task automatic drain(input string name);
    int guard;
    guard     = 0;
    test_name = name;
    @(negedge rd_clk);
    rd_en = 1'b1;
    while (model.size() != 0 || !empty) begin
      guard++;
      if (guard > 4 * DEPTH + 16) begin
        $display("%s: the FIFO did not run empty", name);
        fail_run();
      end
      @(negedge rd_clk);
    end
    rd_en = 1'b0;
    @(negedge rd_clk);
  endtask

  initial begin
    data_t held;
    wr_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    repeat (2) @(posedge rd_clk);
    @(negedge rd_clk);
    compare_flags("reset", 0); // Values straight out of reset.
    check_data("reset", '0, rd_data);
    wr_rst_n = 1'b1;
    settle_check("reset", 0);

    test_name = "fill_no_reads";
    write_burst(DEPTH + 4); // The last four hit full and are dropped.
    settle_check("fill_no_reads", DEPTH);

    drain("drain_in_order");
    settle_check("drain_in_order", 0);
    held  = rd_data;
    rd_en = 1'b1;
    repeat (4) @(negedge rd_clk);
    rd_en = 1'b0;
    @(negedge rd_clk);
    check_data("read_when_empty", held, rd_data);

    test_name = "fill_levels";
    for (int count = 0; count <= DEPTH; count++) begin
      if (count > 0) begin
        write_burst(1);
      end
      settle_check("fill_levels", count);
    end
    drain("fill_levels_drain");

    test_name = "random_traffic";
    rd_seed   = seed ^ 32'h1357;
    fork
      for (int i = 0; i < RAND_CYCLES * 2 / 3; i++) begin
        @(negedge wr_clk);
        r_wr    = $random(seed);
        wr_en   = (i < RAND_CYCLES / 3) ? (r_wr[1:0] != 2'b00) : (r_wr[1:0] == 2'b00);
        wr_data = r_wr[15:8];
      end
      for (int i = 0; i < RAND_CYCLES; i++) begin
        @(negedge rd_clk);
        r_rd  = $random(rd_seed);
        rd_en = r_rd[0];
      end
    join
    @(negedge wr_clk);
    wr_en = 1'b0;
    @(negedge rd_clk);
    rd_en = 1'b0;
    drain("final_drain");
    settle_check("final_drain", 0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* all.f */
+incdir+tb
verilog/afifo_pkg.sv
verilog/gray_ptr_sync.sv
verilog/afifo_wr_ctrl.sv
verilog/afifo_rd_ctrl.sv
verilog/afifo_ram.sv
verilog/async_fifo.sv
tb/tb_async_fifo.sv
